// ==== control_pkg.sv ====
package control_pkg;

  // Command and response widths
  parameter int CMD_ADDR_W = 6;
  parameter int CMD_DATA_W = 32;
  parameter int RESP_W     = 40;
  parameter int ADC_W      = 12;

  // Decoded command addresses
  parameter logic [CMD_ADDR_W-1:0] CMD_KEYING    = 6'h09;
  parameter logic [CMD_ADDR_W-1:0] CMD_HL2_RESET = 6'h3a;

  // Reported when the subsystem was busy at ack time
  parameter logic [CMD_ADDR_W-1:0] RESP_ERR_ADDR = 6'h3f;

  typedef enum logic [1:0] {
    RESP_START = 2'b00,
    RESP_ACK   = 2'b01,
    RESP_READ  = 2'b11,
    RESP_WAIT  = 2'b10
  } resp_state_t;

  typedef enum logic [2:0] {
    FAN_OFF      = 3'b000,
    FAN_LOW      = 3'b001,
    FAN_MED      = 3'b011,
    FAN_FULL     = 3'b010,
    FAN_OVERHEAT = 3'b110
  } fan_state_t;

  // Sensor code is ((T*0.01)+0.5)/3.26*4096
  parameter logic [ADC_W-1:0] TEMP_30C = 12'h3ED;
  parameter logic [ADC_W-1:0] TEMP_35C = 12'h42B;
  parameter logic [ADC_W-1:0] TEMP_40C = 12'h46B;
  parameter logic [ADC_W-1:0] TEMP_45C = 12'h4AA;
  parameter logic [ADC_W-1:0] TEMP_50C = 12'h4E8;
  parameter logic [ADC_W-1:0] TEMP_55C = 12'h527;

  typedef struct packed {
    logic                  flag;
    logic [CMD_ADDR_W-1:0] addr;
    logic                  ptt;
    logic [CMD_DATA_W-1:0] data;
  } resp_cmd_t;

  typedef struct packed {
    logic [2:0]  zero;
    logic [1:0]  slot;
    logic        cw_key;
    logic        rsvd;
    logic        ptt;
    logic [31:0] payload;
  } resp_status_t;

  // One response word, read as command echo or as status slot
  typedef union packed {
    resp_cmd_t    cmd;
    resp_status_t status;
  } resp_word_t;

endpackage

// ==== tick_timer.sv ====
`timescale 1ns/1ps

module tick_timer #(
  parameter int QMSEC_RELOAD = 625
) (
  input  logic clk,
  input  logic slow_adc_rst,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  localparam int CNT_W = $clog2(QMSEC_RELOAD + 1);

  logic [CNT_W-1:0] qms_cnt;
  logic [1:0]       ms_cnt;

  // Quarter tick when the down counter runs out
  assign qmsec_pulse_o = (qms_cnt == '0);
  assign msec_pulse_o  = qmsec_pulse_o & (&ms_cnt);

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      qms_cnt <= CNT_W'(QMSEC_RELOAD);
      ms_cnt  <= 2'b00;
    end else begin
      if (qmsec_pulse_o) begin
        qms_cnt <= CNT_W'(QMSEC_RELOAD);
        // Wraps 0 -> 3 on the first tick, so msec lands on the second
        ms_cnt  <= ms_cnt - 2'b01;
      end else begin
        qms_cnt <= qms_cnt - 1'b1;
      end
    end
  end

  // Quarter tick lasts a single cycle
  a_qmsec_single : assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    qmsec_pulse_o |=> !qmsec_pulse_o
  );

endmodule

// ==== resp_fsm.sv ====
`timescale 1ns/1ps

module resp_fsm (
  input  logic                               clk,
  input  logic                               slow_adc_rst,
  input  logic                               cmd_rqst_i,
  input  logic                               cmd_requires_resp_i,
  input  logic [control_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                               sub_ack_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] sub_resp_data_i,
  input  logic                               resp_rqst_i,
  output logic                               cmd_slot_o,
  output logic                               adc_sample_o,
  output logic [control_pkg::CMD_ADDR_W-1:0] resp_addr_o,
  output logic [control_pkg::CMD_DATA_W-1:0] resp_data_o
);

  import control_pkg::*;

  resp_state_t           state;
  resp_state_t           state_next;
  logic [CMD_ADDR_W-1:0] addr_q;
  logic [CMD_ADDR_W-1:0] addr_next;
  logic [CMD_DATA_W-1:0] data_q;
  logic [CMD_DATA_W-1:0] data_next;
  logic                  resp_odd;
  logic                  cmd_qual;

  assign cmd_qual = cmd_rqst_i & cmd_requires_resp_i;

  // Odd requests sample the ADC, even ones may carry the queued response
  assign adc_sample_o = resp_rqst_i & resp_odd;
  assign cmd_slot_o   = resp_rqst_i & ~resp_odd & (state == RESP_WAIT);

  assign resp_addr_o = addr_q;
  assign resp_data_o = data_q;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state    <= RESP_START;
      resp_odd <= 1'b0;
    end else begin
      state <= state_next;
      if (resp_rqst_i) begin
        resp_odd <= ~resp_odd;
      end
    end
  end

  // Single-entry queued response
  always_ff @(posedge clk) begin
    addr_q <= addr_next;
    data_q <= data_next;
  end

  always_comb begin
    state_next = state;
    addr_next  = addr_q;
    data_next  = data_q;

    case (state)
      RESP_START: begin
        if (cmd_qual) begin
          addr_next  = cmd_addr_i;
          data_next  = cmd_data_i;
          state_next = RESP_ACK;
        end
      end

      RESP_ACK: begin
        if (sub_ack_i) begin
          state_next = RESP_READ;
        end else begin
          // subsystem busy, answer with the error address
          addr_next  = RESP_ERR_ADDR;
          state_next = RESP_WAIT;
        end
      end

      RESP_READ: begin
        // Ack stays low until read data is final
        if (!sub_ack_i) begin
          data_next = sub_resp_data_i;
        end else begin
          state_next = RESP_WAIT;
        end
      end

      RESP_WAIT: begin
        if (cmd_slot_o) begin
          if (cmd_qual) begin
            addr_next  = cmd_addr_i;
            data_next  = cmd_data_i;
            state_next = RESP_ACK;
          end else begin
            state_next = RESP_START;
          end
        end
      end

      default: begin
        state_next = RESP_START;
      end
    endcase
  end

  // A waiting response is not overwritten before its slot comes
  a_queue_held : assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    (state == RESP_WAIT && !cmd_slot_o) |=> ($stable(addr_q) && $stable(data_q))
  );

endmodule

// ==== telemetry_frame.sv ====
`timescale 1ns/1ps

module telemetry_frame #(
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  logic                               clk,
  input  logic                               slow_adc_rst,
  input  logic                               resp_rqst_i,
  input  logic                               cmd_slot_i,
  input  logic [control_pkg::CMD_ADDR_W-1:0] resp_addr_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] resp_data_i,
  input  logic                               ptt_i,
  input  logic                               rxclip_i,
  input  logic [7:0]                         dsiq_status_i,
  input  logic [control_pkg::ADC_W-1:0]      temperature_i,
  input  logic [control_pkg::ADC_W-1:0]      fwd_pwr_i,
  input  logic [control_pkg::ADC_W-1:0]      rev_pwr_i,
  input  logic [control_pkg::ADC_W-1:0]      bias_current_i,
  output logic [control_pkg::RESP_W-1:0]     resp_o,
  output logic                               dsiq_sample_o
);

  import control_pkg::*;

  localparam logic [7:0] STATUS_ID = 8'h1E;
  localparam int         PAD_W     = 16 - ADC_W;

  resp_word_t  resp_q;
  logic [1:0]  slot_q;
  logic [1:0]  clip_cnt;
  logic [31:0] status_payload;

  assign resp_o = resp_q;

  // Payload of the slot that the next request will send
  always_comb begin
    case (slot_q)
      2'b00: status_payload = {STATUS_ID, &clip_cnt, 7'h00, dsiq_status_i, VERSION_MAJOR};
      2'b01: status_payload = {{PAD_W{1'b0}}, temperature_i, {PAD_W{1'b0}}, fwd_pwr_i};
      2'b10: status_payload = {{PAD_W{1'b0}}, rev_pwr_i, {PAD_W{1'b0}}, bias_current_i};
      default: status_payload = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      resp_q        <= {8'h00, STATUS_ID, 16'h0000, VERSION_MAJOR};
      slot_q        <= 2'b00;
      clip_cnt      <= 2'b00;
      dsiq_sample_o <= 1'b0;
    end else if (resp_rqst_i) begin
      // Slot advances even when a command response takes its place
      slot_q   <= slot_q + 2'b01;
      clip_cnt <= 2'b00;
      if (slot_q == 2'b01) begin
        dsiq_sample_o <= ~dsiq_sample_o;
      end
      if (cmd_slot_i) begin
        resp_q.cmd.flag <= 1'b1;
        resp_q.cmd.addr <= resp_addr_i;
        resp_q.cmd.ptt  <= ptt_i;
        resp_q.cmd.data <= resp_data_i;
      end else begin
        resp_q.status.zero    <= 3'b000;
        resp_q.status.slot    <= slot_q;
        resp_q.status.cw_key  <= 1'b0;
        resp_q.status.rsvd    <= 1'b0;
        resp_q.status.ptt     <= ptt_i;
        resp_q.status.payload <= status_payload;
      end
    end else if (clip_cnt != 2'b11) begin
      // Saturates at three clip cycles
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

endmodule

// ==== thermal_fan.sv ====
`timescale 1ns/1ps

module thermal_fan #(
  parameter int PWM_BITS = 16
) (
  input  logic                          clk,
  input  logic                          slow_adc_rst,
  input  logic                          adc_sample_i,
  input  logic [control_pkg::ADC_W-1:0] temperature_i,
  output logic                          fan_pwm_o,
  output logic                          temp_enabletx_o
);

  import control_pkg::*;

  fan_state_t          fan_state;
  fan_state_t          fan_state_next;
  fan_state_t          up_to;
  fan_state_t          dn_to;
  logic [1:0]          up_vote;
  logic [1:0]          up_vote_next;
  logic [1:0]          dn_vote;
  logic [1:0]          dn_vote_next;
  logic                up_hit;
  logic                dn_hit;
  logic [PWM_BITS-1:0] pwm_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      fan_state <= FAN_OFF;
      up_vote   <= 2'b00;
      dn_vote   <= 2'b00;
      pwm_cnt   <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (adc_sample_i) begin
        fan_state <= fan_state_next;
        up_vote   <= up_vote_next;
        dn_vote   <= dn_vote_next;
      end
    end
  end

  // Per state thresholds, neighbours and PWM duty
  always_comb begin
    up_hit          = 1'b0;
    dn_hit          = 1'b0;
    up_to           = fan_state;
    dn_to           = fan_state;
    fan_pwm_o       = 1'b0;
    temp_enabletx_o = 1'b1;

    case (fan_state)
      FAN_OFF: begin
        up_hit = temperature_i > TEMP_35C;
        up_to  = FAN_LOW;
      end
      FAN_LOW: begin
        up_hit    = temperature_i > TEMP_40C;
        dn_hit    = temperature_i < TEMP_30C;
        up_to     = FAN_MED;
        dn_to     = FAN_OFF;
        fan_pwm_o = pwm_cnt[PWM_BITS-1];
      end
      FAN_MED: begin
        up_hit    = temperature_i > TEMP_45C;
        dn_hit    = temperature_i < TEMP_35C;
        up_to     = FAN_FULL;
        dn_to     = FAN_LOW;
        // 75% duty
        fan_pwm_o = pwm_cnt[PWM_BITS-1] | pwm_cnt[PWM_BITS-2];
      end
      FAN_FULL: begin
        up_hit    = temperature_i > TEMP_55C;
        dn_hit    = temperature_i < TEMP_40C;
        up_to     = FAN_OVERHEAT;
        dn_to     = FAN_MED;
        fan_pwm_o = 1'b1;
      end
      FAN_OVERHEAT: begin
        dn_hit          = temperature_i < TEMP_50C;
        dn_to           = FAN_FULL;
        fan_pwm_o       = 1'b1;
        temp_enabletx_o = 1'b0;
      end
      default: begin
        up_to = FAN_OFF;
        dn_to = FAN_OFF;
      end
    endcase
  end

  // Votes decay by one per sample unless the reading keeps pushing
  always_comb begin
    up_vote_next = (up_vote == 2'b00) ? up_vote : up_vote - 2'b01;
    dn_vote_next = (dn_vote == 2'b00) ? dn_vote : dn_vote - 2'b01;
    if (up_hit) begin
      up_vote_next = up_vote + 2'b01;
    end else if (dn_hit) begin
      dn_vote_next = dn_vote + 2'b01;
    end

    fan_state_next = fan_state;
    if (&up_vote) begin
      fan_state_next = up_to;
    end else if (&dn_vote) begin
      fan_state_next = dn_to;
    end
  end

  // Fan speed moves one step at a time, neighbours differ in one bit
  a_state_one_step : assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    (fan_state != $past(fan_state)) |-> $onehot(fan_state ^ $past(fan_state))
  );

endmodule

// ==== tx_keying.sv ====
`timescale 1ns/1ps

module tx_keying (
  input  logic                               clk,
  input  logic                               slow_adc_rst,
  input  logic                               cmd_rqst_i,
  input  logic [control_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                               tx_on_i,
  input  logic                               tx_inhibit_i,
  input  logic                               run_i,
  input  logic                               temp_enabletx_i,
  output logic                               pa_inttr_o,
  output logic                               pa_exttr_o,
  output logic                               pwr_envop_o,
  output logic                               pwr_envpa_o,
  output logic                               pwr_envbias_o,
  output logic                               rffe_rfsw_sel_o,
  output logic                               hl2_reset_o
);

  import control_pkg::*;

  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic hl2_reset_req;
  logic int_tx_on;
  logic pa_path;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      vna           <= 1'b0;
      pa_enable     <= 1'b0;
      tr_disable    <= 1'b0;
      hl2_reset_req <= 1'b0;
    end else if (cmd_rqst_i) begin
      if (cmd_addr_i == CMD_KEYING) begin
        vna        <= cmd_data_i[23];
        pa_enable  <= cmd_data_i[19];
        tr_disable <= cmd_data_i[18];
      end else if (cmd_addr_i == CMD_HL2_RESET) begin
        hl2_reset_req <= cmd_data_i[0];
      end
    end
  end

  assign int_tx_on = tx_on_i & ~tx_inhibit_i & run_i & temp_enabletx_i;

  // PA only in use outside VNA mode
  assign pa_path = ~vna & pa_enable;

  assign pa_exttr_o      = int_tx_on;
  assign pwr_envop_o     = int_tx_on;
  assign pwr_envpa_o     = int_tx_on & pa_path;
  assign pwr_envbias_o   = int_tx_on & pa_path;
  assign pa_inttr_o      = int_tx_on & ~vna & (pa_enable | ~tr_disable);
  assign rffe_rfsw_sel_o = pa_path;

  // Reload from flash only while the host is not running
  assign hl2_reset_o = hl2_reset_req & ~run_i;

endmodule

// ==== control_top.sv ====
`timescale 1ns/1ps

module control_top #(
  parameter int         QMSEC_RELOAD  = 625,
  parameter int         PWM_BITS      = 16,
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  logic                               clk,
  input  logic                               slow_adc_rst,
  input  logic                               cmd_rqst_i,
  input  logic                               cmd_requires_resp_i,
  input  logic [control_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                               sub_ack_i,
  input  logic [control_pkg::CMD_DATA_W-1:0] sub_resp_data_i,
  input  logic                               resp_rqst_i,
  output logic [control_pkg::RESP_W-1:0]     resp_o,
  input  logic                               cw_on_i,
  input  logic                               rxclip_i,
  input  logic [7:0]                         dsiq_status_i,
  output logic                               dsiq_sample_o,
  input  logic [control_pkg::ADC_W-1:0]      temperature_i,
  input  logic [control_pkg::ADC_W-1:0]      fwd_pwr_i,
  input  logic [control_pkg::ADC_W-1:0]      rev_pwr_i,
  input  logic [control_pkg::ADC_W-1:0]      bias_current_i,
  input  logic                               tx_on_i,
  input  logic                               tx_inhibit_i,
  input  logic                               run_i,
  output logic                               fan_pwm_o,
  output logic                               pa_inttr_o,
  output logic                               pa_exttr_o,
  output logic                               pwr_envop_o,
  output logic                               pwr_envpa_o,
  output logic                               pwr_envbias_o,
  output logic                               rffe_rfsw_sel_o,
  output logic                               hl2_reset_o,
  output logic                               qmsec_pulse_o,
  output logic                               msec_pulse_o
);

  import control_pkg::*;

  logic                  cmd_slot;
  logic                  adc_sample;
  logic [CMD_ADDR_W-1:0] resp_addr;
  logic [CMD_DATA_W-1:0] resp_data;
  logic                  temp_enabletx;

  tick_timer #(
    .QMSEC_RELOAD(QMSEC_RELOAD)
  ) tick_timer_inst (
    .clk,
    .slow_adc_rst,
    .qmsec_pulse_o,
    .msec_pulse_o
  );

  resp_fsm resp_fsm_inst (
    .clk,
    .slow_adc_rst,
    .cmd_rqst_i,
    .cmd_requires_resp_i,
    .cmd_addr_i,
    .cmd_data_i,
    .sub_ack_i,
    .sub_resp_data_i,
    .resp_rqst_i,
    .cmd_slot_o   (cmd_slot),
    .adc_sample_o (adc_sample),
    .resp_addr_o  (resp_addr),
    .resp_data_o  (resp_data)
  );

  // PTT flag in the response comes straight from the CW/PTT input
  telemetry_frame #(
    .VERSION_MAJOR(VERSION_MAJOR)
  ) telemetry_frame_inst (
    .clk,
    .slow_adc_rst,
    .resp_rqst_i,
    .cmd_slot_i  (cmd_slot),
    .resp_addr_i (resp_addr),
    .resp_data_i (resp_data),
    .ptt_i       (cw_on_i),
    .rxclip_i,
    .dsiq_status_i,
    .temperature_i,
    .fwd_pwr_i,
    .rev_pwr_i,
    .bias_current_i,
    .resp_o,
    .dsiq_sample_o
  );

  thermal_fan #(
    .PWM_BITS(PWM_BITS)
  ) thermal_fan_inst (
    .clk,
    .slow_adc_rst,
    .adc_sample_i    (adc_sample),
    .temperature_i,
    .fan_pwm_o,
    .temp_enabletx_o (temp_enabletx)
  );

  tx_keying tx_keying_inst (
    .clk,
    .slow_adc_rst,
    .cmd_rqst_i,
    .cmd_addr_i,
    .cmd_data_i,
    .tx_on_i,
    .tx_inhibit_i,
    .run_i,
    .temp_enabletx_i (temp_enabletx),
    .pa_inttr_o,
    .pa_exttr_o,
    .pwr_envop_o,
    .pwr_envpa_o,
    .pwr_envbias_o,
    .rffe_rfsw_sel_o,
    .hl2_reset_o
  );

endmodule

// ==== tb_control.sv ====
`timescale 1ns/1ps

module tb_control;

  import control_pkg::*;

  localparam int         QMSEC_RELOAD  = 9;
  localparam int         PWM_BITS      = 4;
  localparam logic [7:0] VERSION_MAJOR = 8'h48;
  localparam int         PWM_PERIOD    = 1 << PWM_BITS;
  localparam int         TICK_PERIOD   = QMSEC_RELOAD + 1;

  // Cycle budget of each test
  localparam int RESET_CYCLES  = 10;
  localparam int TICK_CYCLES   = 10 * TICK_PERIOD;
  localparam int STATUS_CYCLES = 2 * (4 + 4 * 2);
  localparam int CMD_CYCLES    = 3 * 16;
  localparam int FAN_CYCLES    = 5 * (4 * 4 + 1 + 2 * PWM_PERIOD);
  localparam int KEY_CYCLES    = (8 + 6) * 4;
  localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + TICK_CYCLES + STATUS_CYCLES
                                      + CMD_CYCLES + FAN_CYCLES + KEY_CYCLES);

  logic                  clk;
  logic                  slow_adc_rst;
  logic                  cmd_rqst_i;
  logic                  cmd_requires_resp_i;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  logic [CMD_DATA_W-1:0] cmd_data_i;
  logic                  sub_ack_i;
  logic [CMD_DATA_W-1:0] sub_resp_data_i;
  logic                  resp_rqst_i;
  logic [RESP_W-1:0]     resp_o;
  logic                  cw_on_i;
  logic                  rxclip_i;
  logic [7:0]            dsiq_status_i;
  logic                  dsiq_sample_o;
  logic [ADC_W-1:0]      temperature_i;
  logic [ADC_W-1:0]      fwd_pwr_i;
  logic [ADC_W-1:0]      rev_pwr_i;
  logic [ADC_W-1:0]      bias_current_i;
  logic                  tx_on_i;
  logic                  tx_inhibit_i;
  logic                  run_i;
  logic                  fan_pwm_o;
  logic                  pa_inttr_o;
  logic                  pa_exttr_o;
  logic                  pwr_envop_o;
  logic                  pwr_envpa_o;
  logic                  pwr_envbias_o;
  logic                  rffe_rfsw_sel_o;
  logic                  hl2_reset_o;
  logic                  qmsec_pulse_o;
  logic                  msec_pulse_o;

  resp_word_t  resp_view;
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          cycle_count;

  // Reference model of the request sequence
  logic [1:0] slot_model;
  logic       phase_model;
  logic       dsiq_model;
  logic [1:0] last_slot;
  logic       last_odd;

  assign resp_view = resp_o;

  control_top #(
    .QMSEC_RELOAD  (QMSEC_RELOAD),
    .PWM_BITS      (PWM_BITS),
    .VERSION_MAJOR (VERSION_MAJOR)
  ) control_top_inst (
    .*
  );

  always #2 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        lsb;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  // One-cycle request that returns once the new response word is stable
  task automatic issue_request();
    next_cycle();
    resp_rqst_i = 1'b1;
    next_cycle();
    resp_rqst_i = 1'b0;
    last_odd  = phase_model;
    last_slot = slot_model;
    if (slot_model == 2'd1) begin
      dsiq_model = ~dsiq_model;
    end
    phase_model = ~phase_model;
    slot_model  = slot_model + 2'd1;
    @(negedge clk);
  endtask

  task automatic issue_command(input logic [CMD_ADDR_W-1:0] addr,
                               input logic [CMD_DATA_W-1:0] data, input logic needs_resp);
    next_cycle();
    cmd_rqst_i          = 1'b1;
    cmd_requires_resp_i = needs_resp;
    cmd_addr_i          = addr;
    cmd_data_i          = data;
    next_cycle();
    cmd_rqst_i          = 1'b0;
    cmd_requires_resp_i = 1'b0;
  endtask

  task automatic check_status(input logic clip_sat);
    resp_word_t exp;
    exp.status.zero   = 3'b000;
    exp.status.slot   = last_slot;
    exp.status.cw_key = 1'b0;
    exp.status.rsvd   = 1'b0;
    exp.status.ptt    = cw_on_i;
    case (last_slot)
      2'd0: exp.status.payload = {8'h1E, clip_sat, 7'h00, dsiq_status_i, VERSION_MAJOR};
      2'd1: exp.status.payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2: exp.status.payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: exp.status.payload = 32'h0000_0000;
    endcase
    check_equal(resp_view.status.slot, last_slot, "status slot number");
    check_equal(resp_o, exp, "status word");
    check_equal(dsiq_sample_o, dsiq_model, "dsiq sample toggle");
  endtask

  task automatic tick_spacing();
    int cyc;
    int last_pulse;
    int pulses;
    last_pulse = -1;
    pulses     = 0;
    for (cyc = 0; cyc < TICK_CYCLES; cyc++) begin
      @(negedge clk);
      check_equal(msec_pulse_o & ~qmsec_pulse_o, 1'b0, "msec pulse without qmsec pulse");
      if (qmsec_pulse_o) begin
        pulses++;
        if (pulses == 1) begin
          check_equal(cyc < TICK_PERIOD, 1'b1, "first qmsec pulse in time");
        end else begin
          check_equal(cyc - last_pulse, TICK_PERIOD, "qmsec pulse spacing");
        end
        // Second pulse after reset, then every fourth
        check_equal(msec_pulse_o, (pulses % 4) == 2, "msec pulse position");
        last_pulse = cyc;
      end
    end
    check_equal(pulses, TICK_CYCLES / TICK_PERIOD, "qmsec pulse count");
  endtask

  task automatic status_rotation();
    logic [31:0] r;
    int          round;
    int          k;
    next_cycle();
    r = rand_bits(8);
    dsiq_status_i = r[7:0];
    // Kept below the 35 C threshold so the fan stays off
    r = rand_bits(10);
    temperature_i = {2'b00, r[9:0]};
    r = rand_bits(12);
    fwd_pwr_i = r[11:0];
    r = rand_bits(12);
    rev_pwr_i = r[11:0];
    r = rand_bits(12);
    bias_current_i = r[11:0];
    r = rand_bits(1);
    cw_on_i = r[0];
    for (round = 0; round < 2; round++) begin
      // Three clip cycles in the first round, two in the second
      next_cycle();
      rxclip_i = 1'b1;
      repeat (3 - round) next_cycle();
      rxclip_i = 1'b0;
      for (k = 0; k < 4; k++) begin
        issue_request();
        check_status((k == 0) && (round == 0));
      end
    end
  endtask

  task automatic command_response();
    logic [31:0]           r;
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
    logic [CMD_DATA_W-1:0] rd_data;
    int                    mode;
    // Mode 0 plain ack, mode 1 subsystem busy, mode 2 read with wait cycles
    for (mode = 0; mode < 3; mode++) begin
      next_cycle();
      r = rand_bits(6);
      addr = r[5:0];
      if (addr == CMD_KEYING || addr == CMD_HL2_RESET || addr == RESP_ERR_ADDR) begin
        addr = 6'h15;
      end
      data = rand_bits(32);
      rd_data = rand_bits(32);
      r = rand_bits(1);
      cw_on_i   = r[0];
      sub_ack_i = (mode != 1);
      issue_command(addr, data, 1'b1);
      if (mode == 2) begin
        next_cycle();
        sub_ack_i       = 1'b0;
        sub_resp_data_i = rd_data;
        repeat (2) next_cycle();
        sub_ack_i = 1'b1;
      end
      repeat (3) next_cycle();
      issue_request();
      if (last_odd) begin
        check_status(1'b0);
        issue_request();
      end
      check_equal(resp_view.cmd.flag, 1'b1, "command flag");
      check_equal(resp_view.cmd.addr, (mode == 1) ? RESP_ERR_ADDR : addr, "command address");
      check_equal(resp_view.cmd.ptt, cw_on_i, "command ptt");
      check_equal(resp_view.cmd.data, (mode == 2) ? rd_data : data, "command data");
      check_equal(dsiq_sample_o, dsiq_model, "dsiq sample toggle");
      sub_ack_i = 1'b1;
    end
  endtask

  // Each pair holds exactly one odd request, so one ADC sample
  task automatic request_pair();
    issue_request();
    issue_request();
  endtask

  task automatic measure_duty(output int high);
    high = 0;
    repeat (PWM_PERIOD) begin
      @(negedge clk);
      if (fan_pwm_o) begin
        high++;
      end
    end
  endtask

  task automatic fan_step(input logic [ADC_W-1:0] temp, input int old_duty, input int new_duty,
                          input logic old_tx, input logic new_tx, input string name);
    int high;
    next_cycle();
    temperature_i = temp;
    repeat (3) request_pair();
    measure_duty(high);
    check_equal(high, old_duty, {name, ": duty after three samples"});
    check_equal(pa_exttr_o, old_tx, {name, ": external T/R after three samples"});
    check_equal(pwr_envop_o, old_tx, {name, ": envelope after three samples"});
    request_pair();
    measure_duty(high);
    check_equal(high, new_duty, {name, ": duty after fourth sample"});
    check_equal(pa_exttr_o, new_tx, {name, ": external T/R after fourth sample"});
    check_equal(pwr_envop_o, new_tx, {name, ": envelope after fourth sample"});
  endtask

  task automatic fan_hysteresis();
    next_cycle();
    tx_on_i      = 1'b1;
    run_i        = 1'b1;
    tx_inhibit_i = 1'b0;
    fan_step(TEMP_35C + 12'd8, 0, PWM_PERIOD / 2, 1'b1, 1'b1, "off to low");
    fan_step(TEMP_40C + 12'd8, PWM_PERIOD / 2, 3 * PWM_PERIOD / 4, 1'b1, 1'b1, "low to med");
    fan_step(TEMP_45C + 12'd8, 3 * PWM_PERIOD / 4, PWM_PERIOD, 1'b1, 1'b1, "med to full");
    fan_step(TEMP_55C + 12'd8, PWM_PERIOD, PWM_PERIOD, 1'b1, 1'b0, "full to overheat");
    fan_step(TEMP_50C - 12'd8, PWM_PERIOD, PWM_PERIOD, 1'b0, 1'b1, "overheat to full");
  endtask

  task automatic tx_keying_outputs();
    logic [31:0] r;
    logic [31:0] data;
    logic        tx;
    logic        pa_path;
    int          n;
    // Fan is left at full speed, so temperature allows transmit
    for (n = 0; n < 8; n++) begin
      data = rand_bits(32);
      issue_command(CMD_KEYING, data, 1'b0);
      r = rand_bits(3);
      tx_on_i      = r[0];
      run_i        = r[1];
      tx_inhibit_i = r[2];
      @(negedge clk);
      tx      = tx_on_i & ~tx_inhibit_i & run_i;
      pa_path = ~data[23] & data[19];
      check_equal(pa_exttr_o, tx, "external T/R");
      check_equal(pwr_envop_o, tx, "envelope output");
      check_equal(pwr_envpa_o, tx & pa_path, "PA envelope");
      check_equal(pwr_envbias_o, tx & pa_path, "bias envelope");
      check_equal(pa_inttr_o, tx & ~data[23] & (data[19] | ~data[18]), "internal T/R");
      check_equal(rffe_rfsw_sel_o, pa_path, "RF switch select");
    end
    for (n = 0; n < 6; n++) begin
      data = rand_bits(32);
      issue_command(CMD_HL2_RESET, data, 1'b0);
      r = rand_bits(1);
      run_i = r[0];
      @(negedge clk);
      check_equal(hl2_reset_o, data[0] & ~run_i, "flash reset request");
    end
  endtask

  initial begin
    lfsr                = 32'h8d8617e9;
    errors              = 0;
    checks              = 0;
    cycle_count         = 0;
    slot_model          = 2'd0;
    phase_model         = 1'b0;
    dsiq_model          = 1'b0;
    last_slot           = 2'd0;
    last_odd            = 1'b0;
    clk                 = 1'b0;
    slow_adc_rst        = 1'b1;
    cmd_rqst_i          = 1'b0;
    cmd_requires_resp_i = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    sub_ack_i           = 1'b1;
    sub_resp_data_i     = '0;
    resp_rqst_i         = 1'b0;
    cw_on_i             = 1'b0;
    rxclip_i            = 1'b0;
    dsiq_status_i       = '0;
    temperature_i       = '0;
    fwd_pwr_i           = '0;
    rev_pwr_i           = '0;
    bias_current_i      = '0;
    tx_on_i             = 1'b0;
    tx_inhibit_i        = 1'b0;
    run_i               = 1'b0;

    // Ticks stay quiet while reset is held
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_equal(qmsec_pulse_o | msec_pulse_o, 1'b0, "tick during reset");
    end
    next_cycle();
    slow_adc_rst = 1'b0;

    tick_spacing();
    status_rotation();
    command_response();
    fan_hysteresis();
    tx_keying_outputs();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
control_pkg.sv
tick_timer.sv
resp_fsm.sv
telemetry_frame.sv
thermal_fan.sv
tx_keying.sv
control_top.sv
tb_control.sv

// ==== Makefile ====
TOP = tb_control

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
